// ==== hw/obstacle_pkg.sv ====
// Obstacle field package with screen geometry, obstacle limits and shared widths
`default_nettype none

package obstacle_pkg;

    // ========================================================================
    // Screen and play area
    // ========================================================================
    localparam int SCREEN_WIDTH    = 640;
    localparam int UPPER_BOUND     = 20;
    localparam int LOWER_BOUND     = 460;

    // Distance moved per frame
    localparam int SCROLL_SPEED    = 4;

    // ========================================================================
    // Obstacle shape and spacing limits
    // ========================================================================
    localparam int MIN_WIDTH       = 20;
    localparam int MAX_WIDTH       = 80;
    localparam int MIN_HEIGHT      = 20;
    localparam int MAX_HEIGHT      = 150;
    localparam int MIN_GAP         = 80;
    localparam int MAX_GAP         = 180;

    // Right edge must pass this before the slot is freed
    localparam int DELETE_BOUNDARY = -100;

    // Shown for any slot that is not visible
    localparam int OFF_X           = 700;
    localparam int OFF_Y           = 500;

    localparam int SCORE_MAX       = 9999;

    // ========================================================================
    // Shared types
    // ========================================================================
    typedef logic signed [11:0] pos_x_t;
    typedef logic        [9:0]  scr_x_t;
    typedef logic        [8:0]  scr_y_t;
    typedef logic        [6:0]  width_t;
    typedef logic        [7:0]  height_t;
    typedef logic        [13:0] score_t;

endpackage

`default_nettype wire

// ==== hw/obstacle_if.sv ====
// Spawn strobe and slot state interfaces of the obstacle field
`timescale 1ns/10ps
`default_nettype none

// One-cycle spawn request, fields valid only with spawn high
interface spawn_if;
    import obstacle_pkg::*;

    logic    spawn;
    width_t  width;
    height_t height;
    scr_y_t  y;

    modport send (output spawn, output width, output height, output y);
    modport take (input spawn, input width, input height, input y);
endinterface

// Per-slot state, always valid
interface slot_if #(
    parameter int NUM_OBSTACLES = 10
);
    import obstacle_pkg::*;

    logic    [NUM_OBSTACLES-1:0] active;
    pos_x_t  [NUM_OBSTACLES-1:0] pos_x;
    scr_y_t  [NUM_OBSTACLES-1:0] pos_y;
    width_t  [NUM_OBSTACLES-1:0] width;
    height_t [NUM_OBSTACLES-1:0] height;

    modport owner (output active, output pos_x, output pos_y, output width, output height);
    modport view (input active, input pos_x, input pos_y, input width, input height);
endinterface

`default_nettype wire

// ==== hw/lfsr_rng.sv ====
// Random source, free-running 32-bit Fibonacci LFSR
`timescale 1ns/10ps
`default_nettype none

module lfsr_rng (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] rnd
);
    localparam logic [31:0] SEED = 32'h1234_5678;

    logic [31:0] state;
    logic        fb;

    // Taps 31, 21, 1, 0
    assign fb = state[31] ^ state[21] ^ state[1] ^ state[0];

    // Advances every frame regardless of game mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEED;
        end else begin
            state <= {state[30:0], fb};
        end
    end

    assign rnd = state;

    // All-zero state would lock the generator
    a_never_zero: assert property (@(posedge clk) disable iff (!rst_n) state != '0);

endmodule

`default_nettype wire

// ==== hw/obstacle_spawner.sv ====
// Obstacle spawner, spawn distance tracking and random obstacle shaping
`timescale 1ns/10ps
`default_nettype none

module obstacle_spawner (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        clear,
    input  logic        slot_free,
    input  logic [31:0] rnd,
    spawn_if.send       sp
);
    import obstacle_pkg::*;

    pos_x_t      spawn_dist;
    logic [7:0]  w_sel;
    logic [7:0]  h_sel;
    logic [7:0]  g_sel;
    logic [7:0]  gap;
    logic [8:0]  y_span;
    logic [15:0] y_off;

    // ========================================================================
    // Random shaping, one byte pair per field
    // ========================================================================
    assign w_sel = rnd[7:0] ^ rnd[15:8];
    assign h_sel = rnd[23:16] ^ rnd[31:24];
    assign g_sel = rnd[31:24] ^ rnd[7:0];

    assign sp.width  = width_t'(MIN_WIDTH + w_sel % (MAX_WIDTH - MIN_WIDTH + 1));
    assign sp.height = height_t'(MIN_HEIGHT + h_sel % (MAX_HEIGHT - MIN_HEIGHT + 1));
    assign gap       = 8'(MIN_GAP + g_sel % (MAX_GAP - MIN_GAP + 1));

    // Number of legal top rows so the bottom stays inside the play area
    assign y_span = 9'(LOWER_BOUND - UPPER_BOUND + 1) - {1'b0, sp.height};
    assign y_off  = rnd[27:12] % {7'd0, y_span};
    assign sp.y   = scr_y_t'(UPPER_BOUND + y_off);

    // ========================================================================
    // Spawn decision
    // ========================================================================
    assign sp.spawn = run && !clear && slot_free && (spawn_dist <= SCREEN_WIDTH);

    // Distance holds once a spawn is due and no slot is free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spawn_dist <= pos_x_t'(SCREEN_WIDTH + MIN_GAP);
        end else if (clear) begin
            spawn_dist <= pos_x_t'(SCREEN_WIDTH + MIN_GAP);
        end else if (sp.spawn) begin
            spawn_dist <= pos_x_t'(SCREEN_WIDTH + gap);
        end else if (run && spawn_dist > SCREEN_WIDTH) begin
            spawn_dist <= spawn_dist - pos_x_t'(SCROLL_SPEED);
        end
    end

    a_shape_limits: assert property (@(posedge clk) disable iff (!rst_n)
        sp.spawn |-> (sp.width >= MIN_WIDTH && sp.width <= MAX_WIDTH &&
                      sp.height >= MIN_HEIGHT && sp.height <= MAX_HEIGHT));

endmodule

`default_nettype wire

// ==== hw/obstacle_table.sv ====
// Obstacle table holding slot state, scrolling, spawn insertion and removal count
`timescale 1ns/10ps
`default_nettype none

module obstacle_table #(
    parameter int NUM_OBSTACLES = 10
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       clear,
    spawn_if.take      sp,
    slot_if.owner      slots,
    output logic       slot_free,
    output logic [3:0] removed
);
    import obstacle_pkg::*;

    localparam int IDX_W = $clog2(NUM_OBSTACLES);

    logic    [NUM_OBSTACLES-1:0] active;
    pos_x_t  [NUM_OBSTACLES-1:0] pos_x;
    scr_y_t  [NUM_OBSTACLES-1:0] pos_y;
    width_t  [NUM_OBSTACLES-1:0] wid;
    height_t [NUM_OBSTACLES-1:0] hgt;

    logic    [NUM_OBSTACLES-1:0] rm;
    logic    [IDX_W-1:0]         free_idx;

    // ========================================================================
    // Free slot search and removal detect
    // ========================================================================
    assign slot_free = ~&active;

    // Scan from the top so the lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = NUM_OBSTACLES - 1; i >= 0; i--) begin
            if (!active[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // Right edge past the left margin
    always_comb begin
        removed = '0;
        for (int i = 0; i < NUM_OBSTACLES; i++) begin
            rm[i] = run && active[i] && ((pos_x[i] + pos_x_t'(wid[i])) < DELETE_BOUNDARY);
            removed = removed + {3'd0, rm[i]};
        end
    end

    // ========================================================================
    // Slot state
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= '0;
        end else if (clear) begin
            active <= '0;
        end else begin
            active <= active & ~rm;
            if (sp.spawn) begin
                active[free_idx] <= 1'b1;
            end
        end
    end

    // Payload scrolls each run frame and loads on spawn
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_OBSTACLES; i++) begin
            if (run && !clear && active[i]) begin
                pos_x[i] <= pos_x[i] - pos_x_t'(SCROLL_SPEED);
            end
        end
        if (sp.spawn) begin
            pos_x[free_idx] <= pos_x_t'(SCREEN_WIDTH);
            pos_y[free_idx] <= sp.y;
            wid[free_idx]   <= sp.width;
            hgt[free_idx]   <= sp.height;
        end
    end

    assign slots.active = active;
    assign slots.pos_x  = pos_x;
    assign slots.pos_y  = pos_y;
    assign slots.width  = wid;
    assign slots.height = hgt;

    // Spawner must respect the table's free flag
    a_spawn_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        sp.spawn |-> slot_free);

endmodule

`default_nettype wire

// ==== hw/game_ctrl.sv ====
// Game control, mode tracking, run and clear decode and saturating score
`timescale 1ns/10ps
`default_nettype none

module game_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           gamemode,
    input  logic [3:0]           removed,
    output logic                 run,
    output logic                 clear,
    output obstacle_pkg::score_t score
);
    import obstacle_pkg::*;

    logic [1:0]  prev_mode;
    logic [14:0] score_sum;

    // Idle clears, and so does the first run frame after idle
    assign run   = (gamemode == 2'd1);
    assign clear = (gamemode == 2'd0) || (run && prev_mode == 2'd0);

    assign score_sum = {1'b0, score} + {11'd0, removed};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_mode <= 2'd0;
            score     <= '0;
        end else begin
            prev_mode <= gamemode;
            if (clear) begin
                score <= '0;
            end else if (run) begin
                if (score_sum > SCORE_MAX) begin
                    score <= score_t'(SCORE_MAX);
                end else begin
                    score <= score_sum[13:0];
                end
            end
        end
    end

    a_score_cap: assert property (@(posedge clk) disable iff (!rst_n) score <= SCORE_MAX);

endmodule

`default_nettype wire

// ==== hw/screen_clip.sv ====
// Screen clip, registered per-slot bounding boxes with off-screen substitution
`timescale 1ns/10ps
`default_nettype none

module screen_clip #(
    parameter int NUM_OBSTACLES = 10
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    slot_if.view                                     slots,
    output obstacle_pkg::scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_left,
    output obstacle_pkg::scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_right,
    output obstacle_pkg::scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_up,
    output obstacle_pkg::scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_down
);
    import obstacle_pkg::*;

    logic [NUM_OBSTACLES-1:0] visible;

    // Left edge must be on screen
    always_comb begin
        for (int k = 0; k < NUM_OBSTACLES; k++) begin
            visible[k] = slots.active[k] && (slots.pos_x[k] >= 0) &&
                         (slots.pos_x[k] < SCREEN_WIDTH);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_OBSTACLES; k++) begin
                obstacle_x_left[k]  <= scr_x_t'(OFF_X);
                obstacle_x_right[k] <= scr_x_t'(OFF_X);
                obstacle_y_up[k]    <= scr_y_t'(OFF_Y);
                obstacle_y_down[k]  <= scr_y_t'(OFF_Y);
            end
        end else begin
            for (int k = 0; k < NUM_OBSTACLES; k++) begin
                if (visible[k]) begin
                    obstacle_x_left[k]  <= scr_x_t'(slots.pos_x[k]);
                    obstacle_x_right[k] <= scr_x_t'(slots.pos_x[k] + pos_x_t'(slots.width[k]));
                    obstacle_y_up[k]    <= slots.pos_y[k];
                    obstacle_y_down[k]  <= slots.pos_y[k] + {1'b0, slots.height[k]};
                end else begin
                    obstacle_x_left[k]  <= scr_x_t'(OFF_X);
                    obstacle_x_right[k] <= scr_x_t'(OFF_X);
                    obstacle_y_up[k]    <= scr_y_t'(OFF_Y);
                    obstacle_y_down[k]  <= scr_y_t'(OFF_Y);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/obstacle_map.sv ====
// Obstacle map top level, side-scrolling obstacle field generator
`timescale 1ns/10ps
`default_nettype none

module obstacle_map #(
    parameter int NUM_OBSTACLES = 10
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [1:0]                               gamemode,
    output obstacle_pkg::score_t                     score,
    output obstacle_pkg::scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_left,
    output obstacle_pkg::scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_right,
    output obstacle_pkg::scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_up,
    output obstacle_pkg::scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_down
);
    logic        run;
    logic        clear;
    logic        slot_free;
    logic [3:0]  removed;
    logic [31:0] rnd;

    spawn_if spawn_bus ();
    slot_if #(.NUM_OBSTACLES(NUM_OBSTACLES)) slot_bus ();

    // ========================================================================
    // Control and random source
    // ========================================================================
    game_ctrl u_game_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .gamemode (gamemode),
        .removed  (removed),
        .run      (run),
        .clear    (clear),
        .score    (score)
    );

    lfsr_rng u_lfsr_rng (
        .clk   (clk),
        .rst_n (rst_n),
        .rnd   (rnd)
    );

    // ========================================================================
    // Obstacle datapath
    // ========================================================================
    obstacle_spawner u_spawner (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .clear     (clear),
        .slot_free (slot_free),
        .rnd       (rnd),
        .sp        (spawn_bus.send)
    );

    obstacle_table #(.NUM_OBSTACLES(NUM_OBSTACLES)) u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .clear     (clear),
        .sp        (spawn_bus.take),
        .slots     (slot_bus.owner),
        .slot_free (slot_free),
        .removed   (removed)
    );

    screen_clip #(.NUM_OBSTACLES(NUM_OBSTACLES)) u_clip (
        .clk              (clk),
        .rst_n            (rst_n),
        .slots            (slot_bus.view),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

endmodule

`default_nettype wire

// ==== bench/tb_obstacle_map.sv ====
// Obstacle map testbench running a table of game phases with per-frame box and score checks
`timescale 1ns/10ps
`default_nettype none

module tb_obstacle_map;
    import obstacle_pkg::*;

    localparam int NUM_OBSTACLES = 10;
    localparam int NUM_ROWS      = 7;
    localparam logic [1:0] MODE_IDLE   = 2'd0;
    localparam logic [1:0] MODE_RUN    = 2'd1;
    localparam logic [1:0] MODE_PAUSE  = 2'd2;
    localparam logic [1:0] MODE_FREEZE = 2'd3;

    // ========================================================================
    // Phase table of game mode, frames and lowest score at row end (0 means no floor)
    // ========================================================================
    int tbl_mode      [NUM_ROWS] = '{0, 1, 2, 3, 1, 0, 1};
    int tbl_frames    [NUM_ROWS] = '{5, 400, 10, 10, 200, 3, 50};
    int tbl_min_score [NUM_ROWS] = '{0, 1, 1, 1, 1, 0, 0};

    logic       clk = 1'b0;
    logic       rst_n;
    logic [1:0] gamemode;
    score_t     score;
    scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_left;
    scr_x_t [NUM_OBSTACLES-1:0] obstacle_x_right;
    scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_up;
    scr_y_t [NUM_OBSTACLES-1:0] obstacle_y_down;

    // Values seen at the previous frame
    score_t     prev_score;
    scr_x_t [NUM_OBSTACLES-1:0] prev_left;
    scr_x_t [NUM_OBSTACLES-1:0] prev_right;
    scr_y_t [NUM_OBSTACLES-1:0] prev_up;
    scr_y_t [NUM_OBSTACLES-1:0] prev_down;
    logic [1:0] older_mode;

    int cycle_count = 0;
    int cycle_limit = 0;

    obstacle_map #(.NUM_OBSTACLES(NUM_OBSTACLES)) UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .gamemode         (gamemode),
        .score            (score),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string sig, input int expected, input int actual);
        $display("error: time %0t, %s expected %0d, actual %0d", $time, sig, expected, actual);
        stop_run();
    endtask

    task automatic rule_error(input string what);
        $display("time %0t: %s", $time, what);
        stop_run();
    endtask

    // Both pause modes hold field and score
    function automatic logic is_frozen(input logic [1:0] mode);
        return (mode == MODE_PAUSE) || (mode == MODE_FREEZE);
    endfunction

    // Run length guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            rule_error($sformatf("timeout, run went past %0d cycles", cycle_limit));
        end
    end

    // ========================================================================
    // Frame checks
    // ========================================================================
    task automatic check_box(input int k);
        int left;
        int right;
        int up;
        int down;
        left  = int'(obstacle_x_left[k]);
        right = int'(obstacle_x_right[k]);
        up    = int'(obstacle_y_up[k]);
        down  = int'(obstacle_y_down[k]);
        if (left != OFF_X) begin
            assert (right - left >= MIN_WIDTH && right - left <= MAX_WIDTH)
                else rule_error($sformatf("slot %0d width %0d out of range", k, right - left));
            assert (down - up >= MIN_HEIGHT && down - up <= MAX_HEIGHT)
                else rule_error($sformatf("slot %0d height %0d out of range", k, down - up));
            assert (up >= UPPER_BOUND)
                else rule_error($sformatf("slot %0d top %0d above play area", k, up));
            assert (down <= LOWER_BOUND)
                else rule_error($sformatf("slot %0d bottom %0d below play area", k, down));
            assert (left < SCREEN_WIDTH)
                else rule_error($sformatf("slot %0d left edge %0d off screen", k, left));
        end
    endtask

    task automatic check_idle();
        for (int k = 0; k < NUM_OBSTACLES; k++) begin
            assert (int'(obstacle_x_left[k]) == OFF_X) else value_error(
                $sformatf("obstacle_x_left[%0d]", k), OFF_X, int'(obstacle_x_left[k]));
            assert (int'(obstacle_x_right[k]) == OFF_X) else value_error(
                $sformatf("obstacle_x_right[%0d]", k), OFF_X, int'(obstacle_x_right[k]));
            assert (int'(obstacle_y_up[k]) == OFF_Y) else value_error(
                $sformatf("obstacle_y_up[%0d]", k), OFF_Y, int'(obstacle_y_up[k]));
            assert (int'(obstacle_y_down[k]) == OFF_Y) else value_error(
                $sformatf("obstacle_y_down[%0d]", k), OFF_Y, int'(obstacle_y_down[k]));
        end
        assert (score == '0) else value_error("score", 0, int'(score));
    endtask

    // Boxes hold still while the field is frozen
    task automatic check_frozen();
        for (int k = 0; k < NUM_OBSTACLES; k++) begin
            assert (obstacle_x_left[k] == prev_left[k]) else value_error(
                $sformatf("obstacle_x_left[%0d]", k), int'(prev_left[k]),
                int'(obstacle_x_left[k]));
            assert (obstacle_x_right[k] == prev_right[k]) else value_error(
                $sformatf("obstacle_x_right[%0d]", k), int'(prev_right[k]),
                int'(obstacle_x_right[k]));
            assert (obstacle_y_up[k] == prev_up[k]) else value_error(
                $sformatf("obstacle_y_up[%0d]", k), int'(prev_up[k]), int'(obstacle_y_up[k]));
            assert (obstacle_y_down[k] == prev_down[k]) else value_error(
                $sformatf("obstacle_y_down[%0d]", k), int'(prev_down[k]),
                int'(obstacle_y_down[k]));
        end
    endtask

    // Same obstacle in two frames moves left by one step
    task automatic check_scroll();
        for (int k = 0; k < NUM_OBSTACLES; k++) begin
            if (int'(obstacle_x_left[k]) != OFF_X && int'(prev_left[k]) != OFF_X &&
                obstacle_y_up[k] == prev_up[k]) begin
                assert (int'(obstacle_x_left[k]) == int'(prev_left[k]) - SCROLL_SPEED)
                    else value_error($sformatf("obstacle_x_left[%0d]", k),
                        int'(prev_left[k]) - SCROLL_SPEED, int'(obstacle_x_left[k]));
            end
        end
    endtask

    // Outputs lag slot state by one frame while score follows the current mode
    task automatic check_frame(input logic [1:0] cur_mode);
        assert (int'(score) <= SCORE_MAX)
            else rule_error($sformatf("score %0d above its limit", int'(score)));
        for (int k = 0; k < NUM_OBSTACLES; k++) begin
            check_box(k);
        end
        if (cur_mode == MODE_IDLE && older_mode == MODE_IDLE) begin
            check_idle();
        end
        if (older_mode == MODE_RUN) begin
            check_scroll();
        end
        if (is_frozen(older_mode)) begin
            check_frozen();
        end
        if (is_frozen(cur_mode)) begin
            assert (score == prev_score) else value_error("score", int'(prev_score), int'(score));
        end
        if (cur_mode == MODE_RUN && older_mode == MODE_IDLE) begin
            assert (score == '0) else value_error("score", 0, int'(score));
        end
        if (cur_mode == MODE_RUN && older_mode != MODE_IDLE) begin
            assert (score >= prev_score) else rule_error($sformatf(
                "score fell from %0d to %0d", int'(prev_score), int'(score)));
        end
    endtask

    task automatic save_frame();
        prev_score = score;
        prev_left  = obstacle_x_left;
        prev_right = obstacle_x_right;
        prev_up    = obstacle_y_up;
        prev_down  = obstacle_y_down;
    endtask

    // ========================================================================
    // Phase sequence
    // ========================================================================
    initial begin
        int total;
        rst_n      = 1'b0;
        gamemode   = MODE_IDLE;
        older_mode = MODE_IDLE;
        total      = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total = total + tbl_frames[r];
        end
        cycle_limit = total + 50;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        save_frame();

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int f = 0; f < tbl_frames[r]; f++) begin
                gamemode = 2'(tbl_mode[r]);
                @(negedge clk);
                check_frame(gamemode);
                older_mode = gamemode;
                save_frame();
            end
            if (tbl_min_score[r] > 0) begin
                assert (int'(score) >= tbl_min_score[r]) else rule_error($sformatf(
                    "score %0d at end of phase %0d, at least %0d wanted",
                    int'(score), r, tbl_min_score[r]));
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== obstacle_map.f ====
hw/obstacle_pkg.sv
hw/obstacle_if.sv
hw/lfsr_rng.sv
hw/obstacle_spawner.sv
hw/obstacle_table.sv
hw/game_ctrl.sv
hw/screen_clip.sv
hw/obstacle_map.sv
bench/tb_obstacle_map.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the obstacle_map testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_obstacle_map \
    -f obstacle_map.f \
    -Mdir obj_dir -o tb_obstacle_map
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_obstacle_map > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
